// File: Makefile
TOOL = verilator
FLAGS = --binary --timing --timescale 1ns/100ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps
TOP = cpuTb
FILELIST = vlog.f

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# pass only if the simulation printed the pass line
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: logic/cpuPkg.sv
`default_nettype none

`include "cpu_consts.svh"

package cpuPkg;

	// alu function picked in decode
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor
	} aluOpT;

	// fetch to decode, valid for one cycle per word
	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] instr;
	} fetchT;

	// decode to execute
	typedef struct packed {
		logic valid;
		aluOpT aluOp;
		logic useImm; // operand b is the constant
		logic zeroA; // li forces operand a to zero
		logic [`XLEN-1:0] imm; // already extended
		logic [`XLEN-1:0] rsVal;
		logic [`XLEN-1:0] rtVal;
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic writeEn;
	} execT;

	// result leaving execute, also write port and forward path
	typedef struct packed {
		logic valid;
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic [`XLEN-1:0] value;
	} wbT;

endpackage

`default_nettype wire

// File: logic/cpuTop.sv
`default_nettype none
`timescale 1ns/100ps

`include "cpu_consts.svh"

module cpuTop (
	input logic clk,
	input logic reset,
	input logic imemAck,
	input logic [`XLEN-1:0] imemData,
	output logic imemReq,
	output logic [`PC_WIDTH-1:0] imemAddr,
	output cpuPkg::wbT wb
);

	cpuPkg::fetchT fetch;
	cpuPkg::execT exec;
	logic [`REG_ADDR_WIDTH-1:0] rsAddr;
	logic [`REG_ADDR_WIDTH-1:0] rtAddr;
	logic [`XLEN-1:0] rsData;
	logic [`XLEN-1:0] rtData;

	fetchUnit u_fetch (
		.clk(clk),
		.reset(reset),
		.imemAck(imemAck),
		.imemData(imemData),
		.imemReq(imemReq),
		.imemAddr(imemAddr),
		.fetch(fetch)
	);

	regFile u_regs (
		.clk(clk),
		.wb(wb), // write port
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.rsData(rsData),
		.rtData(rtData)
	);

	decodeUnit u_decode (
		.clk(clk),
		.reset(reset),
		.fetch(fetch),
		.wb(wb), // forwarding source
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.rsData(rsData),
		.rtData(rtData),
		.exec(exec)
	);

	executeUnit u_execute (
		.clk(clk),
		.reset(reset),
		.exec(exec),
		.wb(wb)
	);

endmodule

`default_nettype wire

// File: logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define XLEN 32 // data and instruction width
`define PC_WIDTH 5 // 32 instruction words
`define REG_ADDR_WIDTH 5
`define CONST_WIDTH 15

// opcode field values, bits 31:26
`define OP_NOP 6'd0
`define OP_ADD 6'd1
`define OP_SUB 6'd2
`define OP_AND 6'd3
`define OP_OR 6'd4
`define OP_XOR 6'd5
`define OP_ADDI 6'd8
`define OP_ORI 6'd9
`define OP_LI 6'd10

`endif

// File: logic/decodeUnit.sv
`default_nettype none
`timescale 1ns/100ps

`include "cpu_consts.svh"

module decodeUnit (
	input logic clk,
	input logic reset,
	input cpuPkg::fetchT fetch,
	input cpuPkg::wbT wb,
	output logic [`REG_ADDR_WIDTH-1:0] rsAddr,
	output logic [`REG_ADDR_WIDTH-1:0] rtAddr,
	input logic [`XLEN-1:0] rsData,
	input logic [`XLEN-1:0] rtData,
	output cpuPkg::execT exec
);

	logic [5:0] opcode;
	logic [`REG_ADDR_WIDTH-1:0] rsField;
	logic [`REG_ADDR_WIDTH-1:0] rtField;
	logic [`REG_ADDR_WIDTH-1:0] rdField;
	logic [`REG_ADDR_WIDTH-1:0] dest;
	logic [`CONST_WIDTH-1:0] constField;
	logic known;
	logic rType; // result goes to rd
	logic signExt;
	logic useImm;
	logic zeroA;
	cpuPkg::aluOpT aluOp;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] rsFwd;
	logic [`XLEN-1:0] rtFwd;
	cpuPkg::execT nextExec;

	assign opcode = fetch.instr[31:26];
	assign rsField = fetch.instr[24:20];
	assign rtField = fetch.instr[19:15];
	assign rdField = fetch.instr[14:10];
	assign constField = fetch.instr[14:0];

	always_comb begin
		known = 1'b1;
		rType = 1'b0;
		signExt = 1'b0;
		useImm = 1'b0;
		zeroA = 1'b0;
		aluOp = cpuPkg::aluAdd;
		case (opcode)
			`OP_ADD: rType = 1'b1;
			`OP_SUB: begin
				rType = 1'b1;
				aluOp = cpuPkg::aluSub;
			end
			`OP_AND: begin
				rType = 1'b1;
				aluOp = cpuPkg::aluAnd;
			end
			`OP_OR: begin
				rType = 1'b1;
				aluOp = cpuPkg::aluOr;
			end
			`OP_XOR: begin
				rType = 1'b1;
				aluOp = cpuPkg::aluXor;
			end
			`OP_ADDI: begin
				useImm = 1'b1;
				signExt = 1'b1;
			end
			`OP_ORI: begin
				useImm = 1'b1;
				aluOp = cpuPkg::aluOr;
			end
			`OP_LI: begin
				useImm = 1'b1;
				zeroA = 1'b1; // 0 + constant
			end
			default: known = 1'b0; // nop lands here too
		endcase
	end

	assign imm = signExt ? {{(`XLEN-`CONST_WIDTH){constField[`CONST_WIDTH-1]}}, constField}
		: {{(`XLEN-`CONST_WIDTH){1'b0}}, constField};
	assign dest = rType ? rdField : rtField;

	assign rsAddr = rsField;
	assign rtAddr = rtField;

	// writeback result bypasses the register file write
	assign rsFwd = (wb.valid && (wb.dest == rsField) && (rsField != '0)) ? wb.value : rsData;
	assign rtFwd = (wb.valid && (wb.dest == rtField) && (rtField != '0)) ? wb.value : rtData;

	always_comb begin
		nextExec.valid = fetch.valid;
		nextExec.aluOp = aluOp;
		nextExec.useImm = useImm;
		nextExec.zeroA = zeroA;
		nextExec.imm = imm;
		nextExec.rsVal = rsFwd;
		nextExec.rtVal = rtFwd;
		nextExec.dest = dest;
		nextExec.writeEn = known && (dest != '0); // r0 target is dropped here
	end

	always_ff @(posedge clk) begin
		exec <= nextExec;
		if (reset) exec.valid <= 1'b0;
	end

endmodule

`default_nettype wire

// File: logic/executeUnit.sv
`default_nettype none
`timescale 1ns/100ps

`include "cpu_consts.svh"

module executeUnit (
	input logic clk,
	input logic reset,
	input cpuPkg::execT exec,
	output cpuPkg::wbT wb
);

	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] result;
	cpuPkg::wbT nextWb;

	assign opA = exec.zeroA ? '0 : exec.rsVal;
	assign opB = exec.useImm ? exec.imm : exec.rtVal;

	// plain 32-bit wraparound, no flags kept
	always_comb begin
		case (exec.aluOp)
			cpuPkg::aluAdd: result = opA + opB;
			cpuPkg::aluSub: result = opA - opB;
			cpuPkg::aluAnd: result = opA & opB;
			cpuPkg::aluOr: result = opA | opB;
			cpuPkg::aluXor: result = opA ^ opB;
			default: result = '0;
		endcase
	end

	assign nextWb.valid = exec.valid && exec.writeEn;
	assign nextWb.dest = exec.dest;
	assign nextWb.value = result;

	always_ff @(posedge clk) begin
		wb <= nextWb;
		if (reset) wb.valid <= 1'b0;
	end

endmodule

`default_nettype wire

// File: logic/fetchUnit.sv
`default_nettype none
`timescale 1ns/100ps

`include "cpu_consts.svh"

module fetchUnit (
	input logic clk,
	input logic reset,
	input logic imemAck,
	input logic [`XLEN-1:0] imemData,
	output logic imemReq,
	output logic [`PC_WIDTH-1:0] imemAddr,
	output cpuPkg::fetchT fetch
);

	// four-phase handshake sequence
	typedef enum logic [1:0] {
		fetchIdle, // req low, only right after reset
		fetchReq, // req high, waiting for ack
		fetchDrop // req low, waiting for ack to fall
	} stateT;

	stateT state;
	logic [`PC_WIDTH-1:0] pc;
	logic capture;
	cpuPkg::fetchT nextFetch;

	assign capture = (state == fetchReq) && imemAck;
	assign imemReq = (state == fetchReq);
	assign imemAddr = pc;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= fetchIdle;
			pc <= '0;
		end else begin
			case (state)
				fetchIdle: state <= fetchReq;
				fetchReq: if (imemAck) state <= fetchDrop;
				fetchDrop: if (!imemAck) begin
					pc <= pc + 1'b1; // wraps at 32 words
					state <= fetchReq; // new address goes out with req
				end
				default: state <= fetchIdle;
			endcase
		end
	end

	assign nextFetch.valid = capture;
	assign nextFetch.instr = capture ? imemData : fetch.instr;

	always_ff @(posedge clk) begin
		fetch <= nextFetch;
		if (reset) fetch.valid <= 1'b0;
	end

endmodule

`default_nettype wire

// File: logic/regFile.sv
`default_nettype none
`timescale 1ns/100ps

`include "cpu_consts.svh"

module regFile (
	input logic clk,
	input cpuPkg::wbT wb,
	input logic [`REG_ADDR_WIDTH-1:0] rsAddr,
	input logic [`REG_ADDR_WIDTH-1:0] rtAddr,
	output logic [`XLEN-1:0] rsData,
	output logic [`XLEN-1:0] rtData
);

	logic [`XLEN-1:0] regs [1 << `REG_ADDR_WIDTH];

	// r0 is never stored
	always_ff @(posedge clk) begin
		if (wb.valid && (wb.dest != '0)) regs[wb.dest] <= wb.value;
	end

	assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

`default_nettype wire

// File: tests/cpuTb.sv
`default_nettype none
`timescale 1ns/100ps

`include "cpu_consts.svh"

module cpuTb;

	logic clk = 1'b0;
	logic reset;
	logic imemAck;
	logic [`XLEN-1:0] imemData;
	logic imemReq;
	logic [`PC_WIDTH-1:0] imemAddr;
	cpuPkg::wbT wb;

	integer seed = 55; // ack delay generator
	logic [`XLEN-1:0] progWords[$]; // instruction memory image
	logic [`REG_ADDR_WIDTH-1:0] expDest[$];
	logic [`XLEN-1:0] expValue[$];
	int expIdx = 0; // next expected writeback
	int timeoutCycles = 0;
	logic loaded = 1'b0;

	cpuTop u_dut (
		.clk(clk),
		.reset(reset),
		.imemAck(imemAck),
		.imemData(imemData),
		.imemReq(imemReq),
		.imemAddr(imemAddr),
		.wb(wb)
	);

	// 40 ns period
	initial begin
		forever #20 clk = ~clk;
	end

	task automatic stopRun();
		$display("test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compareValue(
		input string name,
		input logic [31:0] got,
		input logic [31:0] want
	);
		if (got !== want) begin
			$display("ERROR at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, want);
			stopRun();
		end
	endtask

	// word returned for a fetch, nop past the end of the program
	function automatic logic [`XLEN-1:0] wordAt(input logic [`PC_WIDTH-1:0] addr);
		logic [`XLEN-1:0] word;
		if (int'(addr) < progWords.size()) begin
			word = progWords[addr];
		end else begin
			word = '0;
		end
		return word;
	endfunction

	// P lines fill the program, W lines the expected writebacks
	task automatic loadTests();
		int fd;
		int got;
		string line;
		logic [`XLEN-1:0] word;
		int destNum;
		logic [`XLEN-1:0] value;
		fd = $fopen("tests/cpuTests.dat", "r");
		if (fd == 0) begin
			$display("could not open tests/cpuTests.dat");
			stopRun();
		end
		while (!$feof(fd)) begin
			got = $fgets(line, fd);
			if (got == 0 || line.len() == 0) continue;
			case (line.getc(0))
				"P": begin
					got = $sscanf(line, "P %h", word);
					if (got != 1) begin
						$display("malformed program line in tests/cpuTests.dat: %s", line);
						stopRun();
					end
					progWords.push_back(word);
				end
				"W": begin
					got = $sscanf(line, "W %d %h", destNum, value);
					if (got != 2 || destNum < 1 || destNum > 31) begin
						$display("malformed writeback line in tests/cpuTests.dat: %s", line);
						stopRun();
					end
					expDest.push_back(destNum[`REG_ADDR_WIDTH-1:0]);
					expValue.push_back(value);
				end
				default: ; // comments and blank lines
			endcase
		end
		$fclose(fd);
		if (progWords.size() == 0 || progWords.size() > (1 << `PC_WIDTH)) begin
			$display("program in tests/cpuTests.dat is empty or longer than 32 words");
			stopRun();
		end
		if (expDest.size() == 0) begin
			$display("tests/cpuTests.dat lists no expected writebacks");
			stopRun();
		end
	endtask

	initial begin
		reset = 1'b1;
		imemAck = 1'b0;
		imemData = '0;
		loadTests();
		timeoutCycles = 20 * progWords.size() + 100;
		loaded = 1'b1;
		repeat (8) @(negedge clk);
		// outputs settled by the synchronous reset
		compareValue("imemReq", 32'(imemReq), 32'd0);
		compareValue("wb.valid", 32'(wb.valid), 32'd0);
		compareValue("imemAddr", 32'(imemAddr), 32'd0);
		reset = 1'b0;
		while (expIdx < expDest.size()) @(posedge clk);
		repeat (10) @(posedge clk); // window for stray writebacks
		if (expIdx == expDest.size()) begin
			$display("test passed");
			$finish;
		end else begin
			$display("saw %0d writebacks, expected %0d", expIdx, expDest.size());
			stopRun();
		end
	end

	// instruction memory, answers on the falling edge
	initial begin : memResponder
		int delay;
		@(negedge reset);
		forever begin
			@(negedge clk);
			if (imemReq && !imemAck) begin
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(negedge clk);
				imemData = wordAt(imemAddr);
				imemAck = 1'b1;
			end else if (!imemReq && imemAck) begin
				delay = $unsigned($random(seed)) % 4;
				repeat (delay) @(negedge clk);
				imemAck = 1'b0;
			end
		end
	end

	// writeback sequence and fetch address rules, pre-edge values
	initial begin : monitor
		logic [`PC_WIDTH-1:0] lastAddr;
		logic [`PC_WIDTH-1:0] nextAddr;
		logic lastReq;
		logic lastAck;
		logic handshakeDone;
		lastAddr = '0;
		lastReq = 1'b0;
		lastAck = 1'b0;
		handshakeDone = 1'b0;
		@(negedge reset);
		forever begin
			@(posedge clk);
			if (wb.valid) begin
				if (expIdx >= expDest.size()) begin
					$display("unexpected writeback of 0x%08h to r%0d after the last expected one",
						wb.value, wb.dest);
					stopRun();
				end
				compareValue("wb.dest", 32'(wb.dest), 32'(expDest[expIdx]));
				compareValue("wb.value", wb.value, expValue[expIdx]);
				expIdx++;
			end
			if (imemAddr !== lastAddr) begin
				if (lastReq || lastAck) begin
					$display("imemAddr moved from %0d to %0d while a handshake was open",
						lastAddr, imemAddr);
					stopRun();
				end
				if (!handshakeDone) begin
					$display("imemAddr moved from %0d to %0d with no completed handshake",
						lastAddr, imemAddr);
					stopRun();
				end
				nextAddr = lastAddr + 1'b1; // wraps like the pc
				compareValue("imemAddr", 32'(imemAddr), 32'(nextAddr));
				handshakeDone = 1'b0;
			end
			if (imemReq && imemAck) handshakeDone = 1'b1; // word captured here
			lastAddr = imemAddr;
			lastReq = imemReq;
			lastAck = imemAck;
		end
	end

	// bound from the program length
	initial begin : watchdog
		wait (loaded);
		repeat (timeoutCycles) @(posedge clk);
		$display("writebacks stopped arriving, %0d of %0d seen after %0d cycles",
			expIdx, expDest.size(), timeoutCycles);
		stopRun();
	end

endmodule

`default_nettype wire

// File: tests/cpuTests.dat
# P <word>           program word in hex, in order from address 0
# W <dest> <value>   expected writeback, dest in decimal, value in hex
#
# immediate loads, li and ori zero-extend
P 28009234  # li   r1, 0x1234
P 28017FFF  # li   r2, 0x7fff
# r-type ops, results to rd
P 04110C00  # add  r3, r1, r2
P 08111000  # sub  r4, r1, r2   wraps below zero
P 0C321400  # and  r5, r3, r4
P 10119800  # or   r6, r1, r3
P 14411C00  # xor  r7, r4, r2
# addi sign-extends
P 20147FFF  # addi r8, r1, -1
P 20148100  # addi r9, r1, 0x100
P 24454001  # ori  r10, r4, 0x4001
P 2405FFFF  # ori  r11, r0, 0x7fff
P 28064000  # li   r12, 0x4000   bit 14 set, no sign
# no writeback for these three
P 00000000  # nop
P 04110000  # add  r0, r1, r2
P 28000055  # li   r0, 0x55
P 04063400  # add  r13, r0, r12  r0 still zero
# back-to-back dependencies
P 08D60400  # sub  r1, r13, r12
P 08160800  # sub  r2, r1, r12
P 14220800  # xor  r2, r2, r4
P 2021C000  # addi r3, r2, -0x4000
P 18221C00  # unknown opcode 6, no writeback
P 10343800  # or   r14, r3, r8
#
W 1 00001234
W 2 00007FFF
W 3 00009233
W 4 FFFF9235
W 5 00009231
W 6 00009237
W 7 FFFFEDCA
W 8 00001233
W 9 00001334
W 10 FFFFD235
W 11 00007FFF
W 12 00004000
W 13 00004000
W 1 00000000
W 2 FFFFC000
W 2 00005235
W 3 00001235
W 14 00001237

// File: vlog.f
+incdir+logic
logic/cpuPkg.sv
logic/fetchUnit.sv
logic/regFile.sv
logic/decodeUnit.sv
logic/executeUnit.sv
logic/cpuTop.sv
tests/cpuTb.sv
